// ==== hv_shadow.f ====
source/hv_shadow_pkg.sv
source/owt_rx_decode.sv
source/shadow_reg_bank.sv
source/hv_access_notify.sv
source/hv_shadow_top.sv
dv/hv_shadow_tb.sv

// ==== Bender.yml ====
package:
  name: hv_shadow

sources:
  - files:
      - source/hv_shadow_pkg.sv
      - source/owt_rx_decode.sv
      - source/shadow_reg_bank.sv
      - source/hv_access_notify.sv
      - source/hv_shadow_top.sv
  - target: test
    files:
      - dv/hv_shadow_tb.sv

// ==== dv/hv_shadow_tb.sv ====
// hv shadow block testbench
// drives owt responses into the top level, keeps a reference model of the
// shadows and notifications, and checks the DUT against it with assertions
`timescale 1ns/1ps

module hv_shadow_tb;

    localparam int NUM_RANDOM  = 400;
    // reset, directed phase, random phase and drain, with margin
    localparam int CYCLE_LIMIT = 1000;

    logic                       clk;
    logic                       rst_n;
    hv_shadow_pkg::owt_rx_t     rx_in;
    hv_shadow_pkg::hv_shadow_t  shadow;
    logic                       ang_vld;
    logic [7:0]                 ang_data;
    logic                       dgt_vld;

    // reference model state
    hv_shadow_pkg::hv_shadow_t  exp_shadow;
    logic                       exp_ang_vld;
    logic [7:0]                 exp_ang_data;
    logic [1:0]                 dgt_hist;

    logic [31:0] rnd;
    int          err_cnt;
    int          cyc_cnt;
    int          rsp_cnt;

    logic [6:0] shadow_addrs [9] = '{7'h06, 7'h07, 7'h08, 7'h0A, 7'h0C, 7'h0D,
                                     7'h14, 7'h15, 7'h1F};

    hv_shadow_top #(
        .ANA_START (hv_shadow_pkg::ANA_START_DEF),
        .ANA_END   (hv_shadow_pkg::ANA_END_DEF)
    ) uut (
        .i_clk      (clk),
        .i_rst_n    (rst_n),
        .i_owt_rx   (rx_in),
        .o_shadow   (shadow),
        .o_ang_vld  (ang_vld),
        .o_ang_data (ang_data),
        .o_dgt_vld  (dgt_vld)
    );

    always #2 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // ========================================================================
    // reference model
    // ========================================================================
    always @(posedge clk or negedge rst_n) begin
        logic ok;
        logic ana;
        logic dgt;
        if (!rst_n) begin
            exp_shadow   <= '0;
            exp_ang_vld  <= 1'b0;
            exp_ang_data <= '0;
            dgt_hist     <= '0;
        end else begin
            ok  = rx_in.ack && !rx_in.status;
            ana = rx_in.cmd[6:0] >= 7'h30 && rx_in.cmd[6:0] <= 7'h3F;
            dgt = rx_in.cmd[6:0] >= 7'h40 && rx_in.cmd[6:0] <= 7'h43;
            if (ok && !rx_in.cmd[7]) begin
                case (rx_in.cmd[6:0])
                    7'h06: exp_shadow.efuse_cfg <= rx_in.data[7:0];
                    7'h07: exp_shadow.efuse_sts <= rx_in.data[7:0];
                    7'h08: exp_shadow.status1   <= rx_in.data[7:0];
                    7'h0A: exp_shadow.status2   <= rx_in.data[7:0];
                    7'h0C: exp_shadow.status3   <= rx_in.data[7:0];
                    7'h0D: exp_shadow.status4   <= rx_in.data[7:0];
                    7'h14: exp_shadow.bist1     <= rx_in.data[7:0];
                    7'h15: exp_shadow.bist2     <= rx_in.data[7:0];
                    7'h1F: begin
                        exp_shadow.adc1 <= rx_in.data[9:0];
                        exp_shadow.adc2 <= rx_in.data[19:10];
                    end
                    default: ;
                endcase
            end
            exp_ang_vld <= ok && ana;
            if (ok && ana) begin
                exp_ang_data <= rx_in.data[7:0];
            end
            dgt_hist <= {dgt_hist[0], ok && dgt};
        end
    end

    // ========================================================================
    // checks
    // ========================================================================
    shadow_matches: assert property (@(posedge clk) disable iff (!rst_n)
        shadow == exp_shadow)
    else begin
        err_cnt++;
        $display("[FAIL] o_shadow exp 0x%h got 0x%h", $sampled(exp_shadow), $sampled(shadow));
    end

    ang_vld_matches: assert property (@(posedge clk) disable iff (!rst_n)
        ang_vld == exp_ang_vld)
    else begin
        err_cnt++;
        $display("[FAIL] o_ang_vld exp 0x%h got 0x%h", $sampled(exp_ang_vld), $sampled(ang_vld));
    end

    ang_data_matches: assert property (@(posedge clk) disable iff (!rst_n)
        ang_data == exp_ang_data)
    else begin
        err_cnt++;
        $display("[FAIL] o_ang_data exp 0x%h got 0x%h", $sampled(exp_ang_data),
                 $sampled(ang_data));
    end

    dgt_vld_matches: assert property (@(posedge clk) disable iff (!rst_n)
        dgt_vld == dgt_hist[1])
    else begin
        err_cnt++;
        $display("[FAIL] o_dgt_vld exp 0x%h got 0x%h", $sampled(dgt_hist[1]), $sampled(dgt_vld));
    end

    // ========================================================================
    // stimulus
    // ========================================================================
    task automatic drive_rsp(input logic ack, input logic err, input logic rd,
                             input logic [6:0] addr, input logic [19:0] data);
        @(negedge clk);
        rx_in.ack    = ack;
        rx_in.status = err;
        rx_in.cmd    = {rd, addr};
        rx_in.data   = data;
        rsp_cnt++;
    endtask

    task automatic drive_idle(input int n);
        repeat (n) begin
            @(negedge clk);
            rx_in = '0;
        end
    endtask

    always @(posedge clk) begin
        cyc_cnt++;
        if (cyc_cnt >= CYCLE_LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("*** FAILED ***");
            $finish;
        end
    end

    initial begin
        logic [6:0] addr;
        clk     = 1'b0;
        rst_n   = 1'b0;
        rx_in   = '0;
        rnd     = 32'hc054_8034;
        err_cnt = 0;
        cyc_cnt = 0;
        rsp_cnt = 0;
        repeat (8) @(negedge clk);
        rst_n = 1'b1;
        drive_idle(3);

        // every byte shadow, then both adc samples
        for (int i = 0; i < 8; i++) begin
            drive_rsp(1'b1, 1'b0, 1'b0, shadow_addrs[i], {12'hABC, 8'(8'h11 * (i + 1))});
        end
        drive_rsp(1'b1, 1'b0, 1'b0, 7'h1F, 20'h9A5C3);
        // error, read and no-ack leave the shadows alone
        drive_rsp(1'b1, 1'b1, 1'b0, 7'h08, 20'h000FF);
        drive_rsp(1'b1, 1'b0, 1'b1, 7'h0A, 20'h000EE);
        drive_rsp(1'b0, 1'b0, 1'b0, 7'h0C, 20'h000DD);
        drive_rsp(1'b1, 1'b1, 1'b0, 7'h1F, 20'h12345);
        // analog window edges, inside and out
        drive_rsp(1'b1, 1'b0, 1'b0, 7'h30, 20'h0005A);
        drive_rsp(1'b1, 1'b0, 1'b1, 7'h3F, 20'h000C3);
        drive_rsp(1'b1, 1'b1, 1'b0, 7'h35, 20'h00077);
        drive_rsp(1'b1, 1'b0, 1'b0, 7'h2F, 20'h00066);
        drive_idle(1);
        // back-to-back digital hits
        drive_rsp(1'b1, 1'b0, 1'b0, 7'h40, 20'h00001);
        drive_rsp(1'b1, 1'b0, 1'b1, 7'h43, 20'h00002);
        drive_rsp(1'b1, 1'b0, 1'b0, 7'h41, 20'h00003);
        drive_rsp(1'b1, 1'b1, 1'b0, 7'h42, 20'h00004);
        drive_rsp(1'b1, 1'b0, 1'b0, 7'h44, 20'h00005);
        drive_idle(3);

        for (int n = 0; n < NUM_RANDOM; n++) begin
            rnd = xorshift32(rnd);
            case (rnd[1:0])
                2'd0: addr = shadow_addrs[rnd[15:8] % 9];
                2'd1: addr = 7'h30 + 7'(rnd[11:8]);
                2'd2: addr = 7'h40 + 7'(rnd[9:8]);
                default: addr = rnd[14:8];
            endcase
            rnd = xorshift32(rnd);
            drive_rsp(rnd[3:0] != 4'h0, rnd[6:4] == 3'h0, rnd[7], addr, rnd[31:12]);
        end
        drive_idle(4);

        $display("%0d responses in %0d cycles, %0d errors", rsp_cnt, cyc_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// ==== source/hv_shadow_top.sv ====
// hv shadow register block, top level
// decodes owt responses from the hv die, keeps the lv shadow copies
// and raises the analog and digital access notifications
`timescale 1ns/1ps

module hv_shadow_top #(
    parameter logic [hv_shadow_pkg::REG_AW-1:0] ANA_START = hv_shadow_pkg::ANA_START_DEF,
    parameter logic [hv_shadow_pkg::REG_AW-1:0] ANA_END   = hv_shadow_pkg::ANA_END_DEF
) (
    input  logic                             i_clk,
    input  logic                             i_rst_n,
    input  hv_shadow_pkg::owt_rx_t           i_owt_rx,
    output hv_shadow_pkg::hv_shadow_t        o_shadow,
    output logic                             o_ang_vld,
    output logic [hv_shadow_pkg::REG_DW-1:0] o_ang_data,
    output logic                             o_dgt_vld
);

    // qualified access, shared by bank and notifier
    hv_shadow_pkg::reg_acc_t acc;

    owt_rx_decode u_decode (
        .i_rx  (i_owt_rx),
        .o_acc (acc)
    );

    // ========================================================================
    // shadows
    // ========================================================================
    shadow_reg_bank u_bank (
        .i_clk    (i_clk),
        .i_rst_n  (i_rst_n),
        .i_acc    (acc),
        .o_shadow (o_shadow)
    );

    // ========================================================================
    // notifications
    // ========================================================================
    hv_access_notify #(
        .ANA_START (ANA_START),
        .ANA_END   (ANA_END)
    ) u_notify (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_acc      (acc),
        .o_ang_vld  (o_ang_vld),
        .o_ang_data (o_ang_data),
        .o_dgt_vld  (o_dgt_vld)
    );

endmodule

// ==== source/hv_access_notify.sv ====
// hv access notifier
// forwards error-free accesses in the analog window as a one-cycle
// valid with the data byte, and flags digital-list hits two cycles later
`timescale 1ns/1ps

module hv_access_notify #(
    parameter logic [hv_shadow_pkg::REG_AW-1:0] ANA_START = hv_shadow_pkg::ANA_START_DEF,
    parameter logic [hv_shadow_pkg::REG_AW-1:0] ANA_END   = hv_shadow_pkg::ANA_END_DEF
) (
    input  logic                             i_clk,
    input  logic                             i_rst_n,
    input  hv_shadow_pkg::reg_acc_t          i_acc,
    output logic                             o_ang_vld,
    output logic [hv_shadow_pkg::REG_DW-1:0] o_ang_data,
    output logic                             o_dgt_vld
);

    logic ang_hit;
    logic dgt_hit;
    logic dgt_vld_d1;

    // ========================================================================
    // address match
    // ========================================================================
    assign ang_hit = (i_acc.addr >= ANA_START) && (i_acc.addr <= ANA_END);

    always_comb begin
        dgt_hit = 1'b0;
        for (int i = 0; i < hv_shadow_pkg::DGT_NUM; i++) begin
            dgt_hit = dgt_hit | (i_acc.addr == hv_shadow_pkg::DGT_ADDR[i]);
        end
    end

    // ========================================================================
    // analog forward, one cycle
    // ========================================================================
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_ang_vld  <= 1'b0;
            o_ang_data <= '0;
        end else begin
            o_ang_vld <= i_acc.ok & ang_hit;
            // data holds until the next forwarded access
            if (i_acc.ok && ang_hit) begin
                o_ang_data <= i_acc.data.reg_view.val;
            end
        end
    end

    // digital notify, two-stage pipe
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            dgt_vld_d1 <= 1'b0;
            o_dgt_vld  <= 1'b0;
        end else begin
            dgt_vld_d1 <= i_acc.ok & dgt_hit;
            o_dgt_vld  <= dgt_vld_d1;
        end
    end

    // ========================================================================
    // checks
    // ========================================================================
    ang_dgt_disjoint: assert property (
        @(posedge i_clk) disable iff (!i_rst_n) !(ang_hit && dgt_hit)
    ) else $error("analog window overlaps the digital list");

    ang_data_known: assert property (
        @(posedge i_clk) disable iff (!i_rst_n) o_ang_vld |-> !$isunknown(o_ang_data)
    ) else $error("analog valid with unknown data");

endmodule

// ==== source/shadow_reg_bank.sv ====
// hv shadow register bank
// keeps lv copies of nine hv status registers; a qualified write to
// a register address loads its byte, the adc address loads both samples
`timescale 1ns/1ps

module shadow_reg_bank (
    input  logic                      i_clk,
    input  logic                      i_rst_n,
    input  hv_shadow_pkg::reg_acc_t   i_acc,
    output hv_shadow_pkg::hv_shadow_t o_shadow
);

    localparam hv_shadow_pkg::hv_shadow_t SHADOW_RST = '0;

    logic [hv_shadow_pkg::REG_DW-1:0] wr_byte;
    logic [hv_shadow_pkg::ADC_DW-1:0] wr_adc1;
    logic [hv_shadow_pkg::ADC_DW-1:0] wr_adc2;

    // two views of the same data word
    assign wr_byte = i_acc.data.reg_view.val;
    assign wr_adc1 = i_acc.data.adc_view.adc1;
    assign wr_adc2 = i_acc.data.adc_view.adc2;

    // ========================================================================
    // address-matched registers
    // ========================================================================
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_shadow <= SHADOW_RST;
        end else if (i_acc.wr) begin
            case (i_acc.addr)
                hv_shadow_pkg::ADDR_EFUSE_CFG: begin
                    o_shadow.efuse_cfg <= wr_byte;
                end
                hv_shadow_pkg::ADDR_EFUSE_STS: begin
                    o_shadow.efuse_sts <= wr_byte;
                end
                hv_shadow_pkg::ADDR_STATUS1: begin
                    o_shadow.status1 <= wr_byte;
                end
                hv_shadow_pkg::ADDR_STATUS2: begin
                    o_shadow.status2 <= wr_byte;
                end
                hv_shadow_pkg::ADDR_STATUS3: begin
                    o_shadow.status3 <= wr_byte;
                end
                hv_shadow_pkg::ADDR_STATUS4: begin
                    o_shadow.status4 <= wr_byte;
                end
                hv_shadow_pkg::ADDR_BIST1: begin
                    o_shadow.bist1 <= wr_byte;
                end
                hv_shadow_pkg::ADDR_BIST2: begin
                    o_shadow.bist2 <= wr_byte;
                end
                // one response carries both samples
                hv_shadow_pkg::ADDR_ADC: begin
                    o_shadow.adc1 <= wr_adc1;
                    o_shadow.adc2 <= wr_adc2;
                end
                default: begin
                    // other addresses are not shadowed
                end
            endcase
        end
    end

    // ========================================================================
    // checks
    // ========================================================================
    // shadows only move on a qualified write
    shadow_hold_on_idle: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        !i_acc.wr |=> $stable(o_shadow)
    ) else $error("shadow changed without a qualified write");

endmodule

// ==== source/owt_rx_decode.sv ====
// owt response decoder
// qualifies one response from the hv die and splits the command word
// into the write flag and register address; data goes out as the union
`timescale 1ns/1ps

module owt_rx_decode (
    input  hv_shadow_pkg::owt_rx_t  i_rx,
    output hv_shadow_pkg::reg_acc_t o_acc
);

    logic                             rd_flag;
    logic                             rx_ok;
    logic [hv_shadow_pkg::REG_AW-1:0] rx_addr;

    // command word: read flag on top, address below
    assign rd_flag = i_rx.cmd[hv_shadow_pkg::OWT_CMD_W-1];
    assign rx_addr = i_rx.cmd[hv_shadow_pkg::OWT_CMD_W-2:0];

    // error-free response
    assign rx_ok = i_rx.ack & ~i_rx.status;

    assign o_acc.ok   = rx_ok;
    assign o_acc.wr   = rx_ok & ~rd_flag;
    assign o_acc.addr = rx_addr;
    assign o_acc.data = hv_shadow_pkg::owt_data_u'(i_rx.data);

    // ========================================================================
    // checks
    // ========================================================================
    // qualifier fields must be clean whenever the link acks
    always_comb begin
        if (i_rx.ack === 1'b1) begin
            rx_fields_known: assert final (!$isunknown({i_rx.status, i_rx.cmd}))
                else $error("owt ack with unknown status or cmd");
        end
    end

endmodule

// ==== source/hv_shadow_pkg.sv ====
// hv shadow register package
// widths, the hv register map, the analog range defaults, the digital
// address list and the types shared by the decoder, bank and notifier
package hv_shadow_pkg;

    // ========================================================================
    // widths
    // ========================================================================
    localparam int REG_DW     = 8;
    localparam int REG_AW     = 7;
    localparam int ADC_DW     = 10;
    localparam int OWT_CMD_W  = 8;
    localparam int OWT_DATA_W = 2 * ADC_DW;

    // ========================================================================
    // hv register map
    // ========================================================================
    localparam logic [REG_AW-1:0] ADDR_EFUSE_CFG = 7'h06;
    localparam logic [REG_AW-1:0] ADDR_EFUSE_STS = 7'h07;
    localparam logic [REG_AW-1:0] ADDR_STATUS1   = 7'h08;
    localparam logic [REG_AW-1:0] ADDR_STATUS2   = 7'h0A;
    localparam logic [REG_AW-1:0] ADDR_STATUS3   = 7'h0C;
    localparam logic [REG_AW-1:0] ADDR_STATUS4   = 7'h0D;
    localparam logic [REG_AW-1:0] ADDR_BIST1     = 7'h14;
    localparam logic [REG_AW-1:0] ADDR_BIST2     = 7'h15;
    // both adc samples in one response
    localparam logic [REG_AW-1:0] ADDR_ADC       = 7'h1F;

    // analog window, inclusive on both ends
    localparam logic [REG_AW-1:0] ANA_START_DEF  = 7'h30;
    localparam logic [REG_AW-1:0] ANA_END_DEF    = 7'h3F;

    localparam int DGT_NUM = 4;
    localparam logic [DGT_NUM-1:0][REG_AW-1:0] DGT_ADDR = {7'h43, 7'h42, 7'h41, 7'h40};

    // ========================================================================
    // types
    // ========================================================================
    typedef struct packed {
        logic                  ack;
        logic                  status;  // 1 = error
        logic [OWT_CMD_W-1:0]  cmd;     // msb 1 = read
        logic [OWT_DATA_W-1:0] data;
    } owt_rx_t;

    typedef struct packed {
        logic [OWT_DATA_W-REG_DW-1:0] rsvd;
        logic [REG_DW-1:0]            val;
    } reg_view_t;

    typedef struct packed {
        logic [ADC_DW-1:0] adc2;
        logic [ADC_DW-1:0] adc1;
    } adc_view_t;

    typedef union packed {
        reg_view_t reg_view;
        adc_view_t adc_view;
    } owt_data_u;

    typedef struct packed {
        logic              ok;
        logic              wr;
        logic [REG_AW-1:0] addr;
        owt_data_u         data;
    } reg_acc_t;

    typedef struct packed {
        logic [REG_DW-1:0] efuse_cfg;
        logic [REG_DW-1:0] efuse_sts;
        logic [REG_DW-1:0] status1;
        logic [REG_DW-1:0] status2;
        logic [REG_DW-1:0] status3;
        logic [REG_DW-1:0] status4;
        logic [REG_DW-1:0] bist1;
        logic [REG_DW-1:0] bist2;
        logic [ADC_DW-1:0] adc1;
        logic [ADC_DW-1:0] adc2;
    } hv_shadow_t;

endpackage
